// File: src.f
hw/nn_pkg.sv
hw/weight_ram.sv
hw/ram_arbiter.sv
hw/neuron_node.sv
hw/apb_regs.sv
hw/nn_layer_top.sv
sim/nn_chk.sv
sim/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
	-f src.f -Mdir obj_dir -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL TESTS PASSED$" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: sim/tb_top.sv
module tb_top;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_nodes = 4;
	localparam int n_inputs = 8;
	localparam int n_weights = n_nodes * n_inputs;
	localparam int n_tests = 5;
	localparam int clk_period = 20;
	// A weight access may wait a full arbiter round on top of setup, access and idle.
	localparam int xfer_cycles = n_nodes + 6;

	logic clk;
	logic reset;
	logic [nn_pkg::apb_addr_w-1:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [nn_pkg::apb_data_w-1:0] pwdata;
	logic [nn_pkg::apb_data_w-1:0] prdata;
	logic pready;
	logic pslverr;

	int act [n_inputs];
	int bias [n_nodes];
	int wt [n_weights];
	logic [31:0] rdata;
	logic slverr;
	int wait_cycles;
	int errors;
	int checks;
	int test_errors;
	string test_name;

	nn_layer_top #(.n_nodes(n_nodes), .n_inputs(n_inputs)) DUT (
		.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		#(n_tests * 200 * xfer_cycles * clk_period);
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	// One APB transfer; prdata and pslverr are taken at the completing edge.
	task automatic apb_xfer(input logic write, input logic [11:0] addr, input logic [31:0] data);
		@(negedge clk);
		paddr = addr;
		pwrite = write;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		@(posedge clk);
		wait_cycles = 0;
		while (!pready)
		begin
			wait_cycles++;
			@(posedge clk);
		end
		rdata = prdata;
		slverr = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic compare_value(input int expected, input int actual);
		checks++;
		if (expected != actual)
		begin
			$display("** Error %s: expected 0x%0h, actual 0x%0h", test_name, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	// Register accesses never stall, only weight accesses wait for the arbiter.
	task automatic write_reg(input logic [11:0] addr, input int data);
		apb_xfer(1'b1, addr, 32'(data));
		compare_value(0, int'(slverr));
		if (addr < nn_pkg::base_weight)
			compare_value(0, wait_cycles);
	endtask

	task automatic read_reg(input logic [11:0] addr);
		apb_xfer(1'b0, addr, 32'h0);
		compare_value(0, int'(slverr));
		if (addr < nn_pkg::base_weight)
			compare_value(0, wait_cycles);
	endtask

	// Bias times 64 plus the dot product, then ReLU, rounding and saturation.
	function automatic int model_result(input int k);
		int sum;
		int r;
		sum = bias[k] * 64;
		for (int i = 0; i < n_inputs; i++)
			sum += act[i] * wt[k * n_inputs + i];
		if (sum < 0)
			return 0;
		if (sum >= 8192)
			return 127;
		r = (sum >>> 6) + ((sum >>> 5) & 1);
		return (r > 127) ? 127 : r;
	endfunction

	task automatic randomize_layer();
		foreach (act[i])
			act[i] = int'($urandom_range(255)) - 128;
		foreach (bias[k])
			bias[k] = int'($urandom_range(255)) - 128;
		foreach (wt[a])
			wt[a] = int'($urandom_range(255)) - 128;
	endtask

	task automatic load_layer();
		foreach (act[i])
			write_reg(nn_pkg::base_act + 12'(4 * i), act[i]);
		foreach (bias[k])
			write_reg(nn_pkg::base_bias + 12'(4 * k), bias[k]);
		foreach (wt[a])
			write_reg(nn_pkg::base_weight + 12'(4 * a), wt[a]);
	endtask

	task automatic wait_done();
		int polls;
		polls = 0;
		do
		begin
			read_reg(nn_pkg::addr_status);
			polls++;
		end
		while (rdata[1] == 1'b0 && polls < 500);
		if (rdata[1] == 1'b0)
		begin
			$display("%s: the layer never reported done", test_name);
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_results();
		for (int k = 0; k < n_nodes; k++)
		begin
			read_reg(nn_pkg::base_out + 12'(4 * k));
			compare_value(model_result(k), int'(rdata));
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		$display("Test %s: %s", test_name, (test_errors == 0) ? "passed" : "failed");
	endtask

	initial
	begin
		void'($urandom(32'hf82f_7051));
		errors = 0;
		checks = 0;
		wait_cycles = 0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		begin_test("reset_state");
		read_reg(nn_pkg::addr_status);
		compare_value(0, int'(rdata));
		for (int k = 0; k < n_nodes; k++)
		begin
			read_reg(nn_pkg::base_out + 12'(4 * k));
			compare_value(0, int'(rdata));
		end
		end_test();

		begin_test("weight_round_trip");
		randomize_layer();
		foreach (wt[a])
			write_reg(nn_pkg::base_weight + 12'(4 * a), wt[a]);
		foreach (wt[a])
		begin
			read_reg(nn_pkg::base_weight + 12'(4 * a));
			compare_value(wt[a] & 255, int'(rdata));
		end
		end_test();

		begin_test("random_inference");
		repeat (20)
		begin
			randomize_layer();
			load_layer();
			write_reg(nn_pkg::addr_ctrl, 1);
			wait_done();
			check_results();
		end
		end_test();

		// Node 0 goes negative, node 1 saturates, nodes 2 and 3 round up on bit 5.
		begin_test("edge_cases");
		foreach (act[i])
			act[i] = 1;
		bias = '{-128, 127, 0, 1};
		foreach (wt[a])
			wt[a] = (a / n_inputs == 1) ? 127 : 0;
		wt[2 * n_inputs] = 96;
		wt[3 * n_inputs] = -32;
		load_layer();
		write_reg(nn_pkg::addr_ctrl, 1);
		wait_done();
		check_results();
		end_test();

		begin_test("illegal_access");
		randomize_layer();
		load_layer();
		write_reg(nn_pkg::addr_ctrl, 1);
		apb_xfer(1'b1, nn_pkg::base_weight, 32'(~wt[0]));
		compare_value(1, int'(slverr));
		apb_xfer(1'b0, nn_pkg::base_weight + 12'h4, 32'h0);
		compare_value(1, int'(slverr));
		// Different biases would only show up if the second start restarted the nodes.
		foreach (bias[k])
			write_reg(nn_pkg::base_bias + 12'(4 * k), ~bias[k]);
		write_reg(nn_pkg::addr_ctrl, 1);
		wait_done();
		check_results();
		read_reg(nn_pkg::base_weight);
		compare_value(wt[0] & 255, int'(rdata));
		apb_xfer(1'b0, 12'h010, 32'h0);
		compare_value(1, int'(slverr));
		apb_xfer(1'b1, 12'h3fc, 32'h0);
		compare_value(1, int'(slverr));
		apb_xfer(1'b1, nn_pkg::base_out, 32'h0);
		compare_value(1, int'(slverr));
		apb_xfer(1'b1, nn_pkg::addr_status, 32'h0);
		compare_value(1, int'(slverr));
		end_test();

		errors += int'(DUT.u_chk.assert_fails);
		$display("%0d tests, %0d checks, %0d errors (%0d from assertions)",
			n_tests, checks, errors, DUT.u_chk.assert_fails);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: sim/nn_chk.sv
module nn_chk #(
	parameter int n_nodes = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic [nn_pkg::apb_addr_w-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [nn_pkg::apb_data_w-1:0] pwdata,
	input  logic pready,
	input  logic [n_nodes:0] req,
	input  logic [n_nodes:0] gnt
);
	timeunit 1ns;
	timeprecision 1ps;

	int unsigned assert_fails = 0;

	gnt_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(gnt))
	else
	begin
		$error("Arbiter grant is not one-hot.");
		assert_fails++;
	end

	gnt_needs_req: assert property (@(posedge clk) disable iff (reset) (gnt & ~req) == '0)
	else
	begin
		$error("Arbiter granted a requester that was not requesting.");
		assert_fails++;
	end

	// A stalled transfer must hold the bus until pready.
	apb_hold: assert property (@(posedge clk) disable iff (reset)
		psel && penable && !pready |=> psel && penable
		&& $stable(paddr) && $stable(pwrite) && $stable(pwdata))
	else
	begin
		$error("APB signals changed while pready was low.");
		assert_fails++;
	end

endmodule

bind nn_layer_top nn_chk #(.n_nodes(n_nodes)) u_chk (
	.clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
	.pwrite(pwrite), .pwdata(pwdata), .pready(pready), .req(arb_req), .gnt(arb_gnt)
);

// File: hw/nn_layer_top.sv
module nn_layer_top #(
	parameter int n_nodes = 4,
	parameter int n_inputs = 8,
	localparam int n_req = n_nodes + 1,
	localparam int wt_aw = $clog2(n_nodes * n_inputs)
) (
	input  logic clk,
	input  logic reset,
	input  logic [nn_pkg::apb_addr_w-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [nn_pkg::apb_data_w-1:0] pwdata,
	output logic [nn_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	localparam int dw = nn_pkg::data_w;

	logic [n_inputs*dw-1:0] act_vec;
	logic [n_nodes*dw-1:0] bias_vec;
	logic start;
	logic [n_nodes-1:0] node_done;
	logic [n_nodes*dw-1:0] result_vec;
	logic wt_req;
	logic [wt_aw-1:0] wt_addr;
	logic wt_we;
	logic [dw-1:0] wt_wdata;
	logic [n_req-1:0] arb_req;
	logic [n_req-1:0] arb_we;
	logic [n_req-1:0] arb_gnt;
	logic [n_req*wt_aw-1:0] arb_addr;
	logic [n_req*dw-1:0] arb_wdata;
	logic [wt_aw-1:0] mem_addr;
	logic mem_we;
	logic [dw-1:0] mem_wdata;
	logic [dw-1:0] mem_rdata;

	apb_regs #(.n_nodes(n_nodes), .n_inputs(n_inputs)) u_regs (
		.clk(clk), .reset(reset),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.act_vec(act_vec), .bias_vec(bias_vec), .start(start),
		.node_done(node_done), .result_vec(result_vec),
		.wt_req(wt_req), .wt_addr(wt_addr), .wt_we(wt_we), .wt_wdata(wt_wdata),
		.wt_gnt(arb_gnt[nn_pkg::src_apb]), .wt_rdata(mem_rdata)
	);

	assign arb_req[nn_pkg::src_apb] = wt_req;
	assign arb_we[nn_pkg::src_apb] = wt_we;
	assign arb_addr[nn_pkg::src_apb*wt_aw +: wt_aw] = wt_addr;
	assign arb_wdata[nn_pkg::src_apb*dw +: dw] = wt_wdata;

	ram_arbiter #(.n_nodes(n_nodes), .n_inputs(n_inputs)) u_arb (
		.clk(clk), .reset(reset),
		.req(arb_req), .addr_in(arb_addr), .we_in(arb_we), .wdata_in(arb_wdata),
		.gnt(arb_gnt), .mem_addr(mem_addr), .mem_we(mem_we), .mem_wdata(mem_wdata)
	);

	weight_ram #(.n_nodes(n_nodes), .n_inputs(n_inputs)) u_ram (
		.clk(clk), .addr(mem_addr), .we(mem_we), .wdata(mem_wdata), .rdata(mem_rdata)
	);

	// Nodes only read, so their write slots stay idle.
	for (genvar k = 0; k < n_nodes; k++)
	begin : g_node
		localparam int slot = nn_pkg::src_node_base + k;

		assign arb_we[slot] = 1'b0;
		assign arb_wdata[slot*dw +: dw] = '0;

		neuron_node #(.n_nodes(n_nodes), .n_inputs(n_inputs), .node_index(k)) u_node (
			.clk(clk), .reset(reset), .start(start),
			.act_vec(act_vec), .bias(bias_vec[k*dw +: dw]),
			.req(arb_req[slot]), .addr(arb_addr[slot*wt_aw +: wt_aw]),
			.gnt(arb_gnt[slot]), .rdata(mem_rdata),
			.result(result_vec[k*dw +: dw]), .done(node_done[k])
		);
	end

endmodule

// File: hw/apb_regs.sv
module apb_regs #(
	parameter int n_nodes = 4,
	parameter int n_inputs = 8,
	localparam int wt_aw = $clog2(n_nodes * n_inputs)
) (
	input  logic clk,
	input  logic reset,
	input  logic [nn_pkg::apb_addr_w-1:0] paddr,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [nn_pkg::apb_data_w-1:0] pwdata,
	output logic [nn_pkg::apb_data_w-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic [n_inputs*nn_pkg::data_w-1:0] act_vec,
	output logic [n_nodes*nn_pkg::data_w-1:0] bias_vec,
	output logic start,
	input  logic [n_nodes-1:0] node_done,
	input  logic [n_nodes*nn_pkg::data_w-1:0] result_vec,
	output logic wt_req,
	output logic [wt_aw-1:0] wt_addr,
	output logic wt_we,
	output logic [nn_pkg::data_w-1:0] wt_wdata,
	input  logic wt_gnt,
	input  logic [nn_pkg::data_w-1:0] wt_rdata
);
	localparam int aw = nn_pkg::apb_addr_w;
	localparam int dw = nn_pkg::data_w;

	logic [dw-1:0] act_q [n_inputs];
	logic [dw-1:0] bias_q [n_nodes];
	logic busy;
	logic done_flag;
	logic rd_pend;
	logic access;
	logic aligned;
	logic [aw-1:0] bias_off;
	logic [aw-1:0] act_off;
	logic [aw-1:0] out_off;
	logic [aw-1:0] wt_off;
	logic hit_ctrl;
	logic hit_status;
	logic hit_bias;
	logic hit_act;
	logic hit_out;
	logic hit_wt;
	logic mapped;
	logic err;
	logic wt_stall;

	assign access = psel & penable;
	assign aligned = (paddr[1:0] == 2'b00);
	assign bias_off = paddr - nn_pkg::base_bias;
	assign act_off = paddr - nn_pkg::base_act;
	assign out_off = paddr - nn_pkg::base_out;
	assign wt_off = paddr - nn_pkg::base_weight;

	assign hit_ctrl = (paddr == nn_pkg::addr_ctrl);
	assign hit_status = (paddr == nn_pkg::addr_status);
	assign hit_bias = aligned && paddr >= nn_pkg::base_bias && bias_off[aw-1:2] < n_nodes;
	assign hit_act = aligned && paddr >= nn_pkg::base_act && act_off[aw-1:2] < n_inputs;
	assign hit_out = aligned && paddr >= nn_pkg::base_out && out_off[aw-1:2] < n_nodes;
	assign hit_wt = aligned && paddr >= nn_pkg::base_weight
		&& wt_off[aw-1:2] < n_nodes * n_inputs;
	assign mapped = hit_ctrl | hit_status | hit_bias | hit_act | hit_out | hit_wt;

	// Weights belong to the nodes while a run is in progress.
	assign err = !mapped || (hit_wt && busy) || (pwrite && (hit_status || hit_out));

	// A legal weight access waits for the arbiter, a read one cycle more for the data.
	assign wt_stall = access & hit_wt & ~busy;
	assign wt_req = wt_stall & ~rd_pend;
	assign wt_addr = wt_off[wt_aw+1:2];
	assign wt_we = pwrite;
	assign wt_wdata = pwdata[dw-1:0];

	assign pready = !wt_stall || (wt_gnt && pwrite) || rd_pend;
	assign pslverr = access & err;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			start <= 1'b0;
			busy <= 1'b0;
			done_flag <= 1'b0;
			rd_pend <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			rd_pend <= wt_gnt & ~pwrite;
			if (access && pwrite && hit_ctrl && pwdata[0] && !busy)
			begin
				start <= 1'b1;
				busy <= 1'b1;
				done_flag <= 1'b0;
			end
			else if (busy && !start && &node_done)
			begin
				busy <= 1'b0;
				done_flag <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (access && pwrite)
		begin
			for (int k = 0; k < n_nodes; k++)
				if (hit_bias && bias_off[aw-1:2] == k)
					bias_q[k] <= pwdata[dw-1:0];
			for (int i = 0; i < n_inputs; i++)
				if (hit_act && act_off[aw-1:2] == i)
					act_q[i] <= pwdata[dw-1:0];
		end
	end

	always_comb
	begin
		for (int i = 0; i < n_inputs; i++)
			act_vec[i*dw +: dw] = act_q[i];
		for (int k = 0; k < n_nodes; k++)
			bias_vec[k*dw +: dw] = bias_q[k];
	end

	always_comb
	begin
		prdata = '0;
		if (rd_pend)
			prdata[dw-1:0] = wt_rdata;
		else if (hit_status)
			prdata[1:0] = {done_flag, busy};
		else
		begin
			for (int k = 0; k < n_nodes; k++)
			begin
				if (hit_bias && bias_off[aw-1:2] == k)
					prdata[dw-1:0] = bias_q[k];
				if (hit_out && out_off[aw-1:2] == k)
					prdata[dw-1:0] = result_vec[k*dw +: dw];
			end
			for (int i = 0; i < n_inputs; i++)
				if (hit_act && act_off[aw-1:2] == i)
					prdata[dw-1:0] = act_q[i];
		end
	end

endmodule

// File: hw/neuron_node.sv
module neuron_node #(
	parameter int n_nodes = 4,
	parameter int n_inputs = 8,
	parameter int node_index = 0,
	localparam int wt_aw = $clog2(n_nodes * n_inputs),
	localparam int cnt_w = (n_inputs > 1) ? $clog2(n_inputs) : 1
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [n_inputs*nn_pkg::data_w-1:0] act_vec,
	input  logic [nn_pkg::data_w-1:0] bias,
	output logic req,
	output logic [wt_aw-1:0] addr,
	input  logic gnt,
	input  logic [nn_pkg::data_w-1:0] rdata,
	output logic [nn_pkg::data_w-1:0] result,
	output logic done
);
	localparam int dw = nn_pkg::data_w;
	localparam int pw = nn_pkg::prod_w;
	localparam int acw = nn_pkg::acc_w;
	localparam int fb = nn_pkg::frac_bits;
	// Sums of 2**13 and more no longer fit the 8-bit result.
	localparam int sat_bit = dw - 1 + fb;
	localparam logic [dw-1:0] max_out = {1'b0, {(dw-1){1'b1}}};

	nn_pkg::node_state_t state;
	logic [cnt_w-1:0] cnt;
	logic signed [acw-1:0] acc;
	logic [dw-1:0] act_sel;
	logic signed [pw-1:0] prod;
	logic [acw-1:0] bias_ext;
	logic [acw-1:0] prod_ext;
	logic [dw-1:0] rounded;
	logic [dw-1:0] relu_out;

	assign req = (state == nn_pkg::request);
	assign addr = wt_aw'(node_index * n_inputs) + wt_aw'(cnt);

	assign act_sel = act_vec[cnt*dw +: dw];
	assign prod = pw'($signed(act_sel)) * pw'($signed(rdata));
	assign prod_ext = {{(acw-pw){prod[pw-1]}}, prod};
	assign bias_ext = {{(acw-dw-fb){bias[dw-1]}}, bias, {fb{1'b0}}};

	// Bit 5 of the sum rounds the integer part to nearest.
	assign rounded = {1'b0, acc[sat_bit-1:fb]} + {{(dw-1){1'b0}}, acc[fb-1]};

	always_comb
	begin
		if (acc[acw-1])
			relu_out = '0;
		else if (acc[acw-2:sat_bit] != '0 || rounded[dw-1])
			relu_out = max_out;
		else
			relu_out = rounded;
	end

	always_ff @(posedge clk)
	begin
		if (state == nn_pkg::idle && start)
			acc <= bias_ext;
		else if (state == nn_pkg::accumulate)
			acc <= acc + prod_ext;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= nn_pkg::idle;
			cnt <= '0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			case (state)
				nn_pkg::idle:
				begin
					if (start)
					begin
						cnt <= '0;
						done <= 1'b0;
						state <= nn_pkg::request;
					end
				end
				nn_pkg::request:
				begin
					if (gnt)
						state <= nn_pkg::accumulate;
				end
				nn_pkg::accumulate:
				begin
					// The weight arrives here, one cycle after the grant.
					if (cnt == cnt_w'(n_inputs - 1))
						state <= nn_pkg::finish;
					else
					begin
						cnt <= cnt + 1'b1;
						state <= nn_pkg::request;
					end
				end
				nn_pkg::finish:
				begin
					result <= relu_out;
					done <= 1'b1;
					state <= nn_pkg::idle;
				end
				default:
					state <= nn_pkg::idle;
			endcase
		end
	end

endmodule

// File: hw/ram_arbiter.sv
module ram_arbiter #(
	parameter int n_nodes = 4,
	parameter int n_inputs = 8,
	localparam int n_req = n_nodes + 1,
	localparam int wt_aw = $clog2(n_nodes * n_inputs),
	localparam int ptr_w = $clog2(n_req)
) (
	input  logic clk,
	input  logic reset,
	input  logic [n_req-1:0] req,
	input  logic [n_req*wt_aw-1:0] addr_in,
	input  logic [n_req-1:0] we_in,
	input  logic [n_req*nn_pkg::data_w-1:0] wdata_in,
	output logic [n_req-1:0] gnt,
	output logic [wt_aw-1:0] mem_addr,
	output logic mem_we,
	output logic [nn_pkg::data_w-1:0] mem_wdata
);
	logic [ptr_w-1:0] last;
	logic [ptr_w-1:0] sel;
	logic any;

	// Search starts just past the requester served last.
	always_comb
	begin
		int idx;
		gnt = '0;
		sel = '0;
		any = 1'b0;
		for (int k = 1; k <= n_req; k++)
		begin
			idx = int'(last) + k;
			if (idx >= n_req)
				idx = idx - n_req;
			if (!any && req[idx])
			begin
				gnt[idx] = 1'b1;
				sel = ptr_w'(idx);
				any = 1'b1;
			end
		end
	end

	assign mem_addr = addr_in[sel*wt_aw +: wt_aw];
	assign mem_we = any & we_in[sel];
	assign mem_wdata = wdata_in[sel*nn_pkg::data_w +: nn_pkg::data_w];

	always_ff @(posedge clk)
	begin
		if (reset)
			last <= ptr_w'(n_req - 1);
		else if (any)
			last <= sel;
	end

endmodule

// File: hw/weight_ram.sv
module weight_ram #(
	parameter int n_nodes = 4,
	parameter int n_inputs = 8,
	localparam int depth = n_nodes * n_inputs,
	localparam int wt_aw = $clog2(depth)
) (
	input  logic clk,
	input  logic [wt_aw-1:0] addr,
	input  logic we,
	input  logic [nn_pkg::data_w-1:0] wdata,
	output logic [nn_pkg::data_w-1:0] rdata
);
	logic [nn_pkg::data_w-1:0] mem [depth];

	// Weight of node k, input i sits at word k*n_inputs + i.
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

// File: hw/nn_pkg.sv
package nn_pkg;

	// Fixed-point format of activations, weights, biases and results.
	localparam int data_w = 8;
	localparam int prod_w = 16;
	localparam int acc_w = 23;
	localparam int frac_bits = 6;

	localparam int apb_addr_w = 12;
	localparam int apb_data_w = 32;

	// APB byte offsets, registers are one word apart.
	localparam logic [apb_addr_w-1:0] addr_ctrl = 12'h000;
	localparam logic [apb_addr_w-1:0] addr_status = 12'h004;
	localparam logic [apb_addr_w-1:0] base_bias = 12'h040;
	localparam logic [apb_addr_w-1:0] base_act = 12'h080;
	localparam logic [apb_addr_w-1:0] base_out = 12'h0C0;
	localparam logic [apb_addr_w-1:0] base_weight = 12'h400;

	typedef enum logic [1:0] {
		idle,
		request,
		accumulate,
		finish
	} node_state_t;

	// The APB port takes slot 0 of the arbiter and node k takes slot k+1.
	typedef enum int {
		src_apb = 0,
		src_node_base = 1
	} req_src_t;

endpackage
